// File: Makefile
VERILATOR  ?= verilator
TOP        := datapath_tb
FILELIST   := datapath.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim build clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the simulator output
sim: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/datapath_patterns.hex
// word 0 is the program length, then the program image from address 0,
// then the count of WWD values, the WWD values in order, and the final num_inst
0038
// 00-17 alu: lhi, ori, adi, then add sub and orr not tcp shl shr into r3
6112 F41C 5534 F41C
42FB F81C F6C0 FC1C
F6C1 FC1C F6C2 FC1C
F6C3 FC1C F4C4 FC1C
F4C5 FC1C F4C6 FC1C
F8C7 FC1C 447F F01C
// 18-21 forwarding chain, two writers of r3 back to back at 1e and 1f
6000 4003 F040 F480
F9C1 FC1C FEC3 FCC6
FC1C F81C 61A5 555A
// 22-2d store then load, load-use stalls, negative offset
8120 7220 F81C 7320
FCC0 FC1C 4040 80F0
71F0 F41C 9031 F81C
// 2e jmp to 31, slots at 2f and 30 must not run, jmp at 33 skips 34
61EE 4501 F41C 9035
// 36 hlt, the wwd behind it is never fetched
F81C F01C F01D F81C
// expected WWD values
0014
1200 1234 FFFB 122F
1239 1230 FFFF EDCB
EDCC 2468 FFFD 12B3
0003 0016 0009
A55A A55D 0043
0044 0043
// retired instructions, hlt included
0034

// File: bench/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;
	import cpu_pkg::*;

	localparam int MEM_DEPTH = 256;
	localparam int PATTERN_DEPTH = 512;
	localparam int NUM_WWD_TESTS = 4;

	logic clk;
	logic reset_n;
	word_t data1_i = '0;
	word_t data2_i = '0;
	logic read_m1_o;
	logic read_m2_o;
	logic write_m2_o;
	word_t address1_o;
	word_t address2_o;
	word_t data2_o;
	word_t num_inst_o;
	word_t output_port_o;
	logic is_halted_o;

	word_t imem [MEM_DEPTH];
	word_t dmem [MEM_DEPTH];
	word_t pattern_mem [PATTERN_DEPTH];
	word_t expected_port [$];
	word_t port_log [$];
	word_t last_port = '0;
	word_t expected_num_inst;
	int cycle_limit;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string abort_reason = "";

	// output port updates owned by each test in program order
	string wwd_test_name [NUM_WWD_TESTS] = '{"alu", "forwarding", "load_store", "jump"};
	int wwd_test_len [NUM_WWD_TESTS] = '{12, 3, 3, 2};

	datapath datapath_i (
		.clk(clk), .reset_n(reset_n), .read_m1_o(read_m1_o), .address1_o(address1_o),
		.data1_i(data1_i), .read_m2_o(read_m2_o), .write_m2_o(write_m2_o),
		.address2_o(address2_o), .data2_i(data2_i), .data2_o(data2_o),
		.num_inst_o(num_inst_o), .output_port_o(output_port_o), .is_halted_o(is_halted_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// zero-wait memories with the store landing before the read of the same cycle
	always @(negedge clk) begin
		if (write_m2_o === 1'b1 && address2_o < MEM_DEPTH)
			dmem[address2_o[7:0]] = data2_o;
		data1_i <= (address1_o < MEM_DEPTH) ? imem[address1_o[7:0]] : '0;
		// load data only comes back on a read strobe
		if (read_m2_o === 1'b1 && address2_o < MEM_DEPTH)
			data2_i <= dmem[address2_o[7:0]];
		else
			data2_i <= '0;
	end

	// queue position is the WWD index
	always @(negedge clk) begin
		if (reset_n === 1'b1 && output_port_o !== last_port) begin
			port_log.push_back(output_port_o);
			last_port = output_port_o;
		end
	end

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d mismatches", name, error_count - errors_before);
		end
	endtask

	task automatic load_patterns();
		int prog_len;
		int base;
		int wwd_count;
		int table_total;
		table_total = 0;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			imem[i] = '0;
			dmem[i] = '0;
		end
		$readmemh("bench/datapath_patterns.hex", pattern_mem);
		for (int t = 0; t < NUM_WWD_TESTS; t++)
			table_total += wwd_test_len[t];
		prog_len = int'(pattern_mem[0]);
		if ($isunknown(pattern_mem[0]) || prog_len == 0 || prog_len > MEM_DEPTH) begin
			abort_reason = "pattern file is missing or has no usable program length";
		end else begin
			for (int i = 0; i < prog_len; i++)
				imem[i] = pattern_mem[1 + i];
			base = prog_len + 1;
			wwd_count = int'(pattern_mem[base]);
			if ($isunknown(pattern_mem[base + wwd_count + 1]) || wwd_count != table_total) begin
				abort_reason = "pattern file is truncated or its WWD count does not fit the tests";
			end else begin
				for (int k = 0; k < wwd_count; k++)
					expected_port.push_back(pattern_mem[base + 1 + k]);
				expected_num_inst = pattern_mem[base + wwd_count + 1];
				// worst case a few bubbles per word plus pipeline fill and reset
				cycle_limit = 8 * prog_len + 50;
			end
		end
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	endtask

	task automatic wait_for_halt();
		int cycles;
		cycles = 0;
		while (is_halted_o !== 1'b1 && cycles < cycle_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (is_halted_o !== 1'b1)
			abort_reason = $sformatf("the CPU never halted within %0d cycles", cycle_limit);
	endtask

	task automatic check_port_range(input string name, input int first, input int count);
		int errors_before;
		errors_before = error_count;
		for (int k = first; k < first + count; k++) begin
			if (k < port_log.size()) begin
				check_word($sformatf("%s wwd %0d", name, k), expected_port[k], port_log[k]);
			end else begin
				$display("%s: output port update %0d never happened", name, k);
				error_count++;
			end
		end
		report_test(name, errors_before);
	endtask

	task automatic check_halt();
		int errors_before;
		word_t last_value;
		errors_before = error_count;
		last_value = expected_port[expected_port.size() - 1];
		check_flag("halt fetch stopped", 1'b0, read_m1_o);
		check_flag("halt data read idle", 1'b0, read_m2_o);
		check_word("halt num_inst", expected_num_inst, num_inst_o);
		check_word("halt wwd count", word_t'(expected_port.size()), word_t'(port_log.size()));
		// halt flag, output port and counter stay put once halted
		repeat (10) begin
			@(negedge clk);
			check_flag("halt is_halted hold", 1'b1, is_halted_o);
			check_word("halt output hold", last_value, output_port_o);
		end
		check_word("halt num_inst hold", expected_num_inst, num_inst_o);
		report_test("halt", errors_before);
	endtask

	initial begin
		int first;
		reset_n = 1'b0;
		first = 0;
		load_patterns();
		if (abort_reason == "") begin
			apply_reset();
			wait_for_halt();
		end
		if (abort_reason == "") begin
			for (int t = 0; t < NUM_WWD_TESTS; t++) begin
				check_port_range(wwd_test_name[t], first, wwd_test_len[t]);
				first += wwd_test_len[t];
			end
			check_halt();
		end else begin
			$display("%s", abort_reason);
			error_count++;
		end
		$display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, error_count);
		if (abort_reason == "" && error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: datapath.f
+incdir+include
design/cpu_pkg.sv
design/pipe_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/datapath.sv
bench/datapath_tb.sv

// File: design/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	// data word, also used for instruction and data addresses
	typedef logic [`WORD_SIZE-1:0] word_t;

	// register number
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// instruction opcode field
	typedef logic [`OP_HI-`OP_LO:0] opcode_t;

	// R-type function field
	typedef logic [`FN_HI-`FN_LO:0] func_t;

	// ALU operation picked in decode
	typedef logic [3:0] alu_sel_t;

	// operand source for execute: register file, EX/MEM or MEM/WB
	typedef logic [1:0] fwd_sel_t;

endpackage

// File: design/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic           clk,
	input  logic           reset_n,
	output logic           read_m1_o,
	output cpu_pkg::word_t address1_o,
	input  cpu_pkg::word_t data1_i,
	output logic           read_m2_o,
	output logic           write_m2_o,
	output cpu_pkg::word_t address2_o,
	input  cpu_pkg::word_t data2_i,
	output cpu_pkg::word_t data2_o,
	output cpu_pkg::word_t num_inst_o,
	output cpu_pkg::word_t output_port_o,
	output logic           is_halted_o
);
	import cpu_pkg::*;

	// hazard and redirect control from decode to fetch
	logic stall;
	logic redirect;
	word_t target;
	logic freeze;
	logic squash;

	// IF/ID
	word_t if_instr;
	word_t if_pc;
	logic if_valid;

	// register file reads
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t rs_val;
	word_t rt_val;

	// write-back, also the MEM/WB forwarding path
	logic wb_reg_write;
	reg_addr_t wb_dest;
	word_t wb_data;

	id_ex_if id_ex ();
	ex_mem_if ex_mem ();

	fetch_stage fetch_i (
		.clk(clk), .reset_n(reset_n), .stall_i(stall), .redirect_i(redirect),
		.target_i(target), .freeze_i(freeze), .squash_i(squash), .instr_i(data1_i),
		.pc_o(address1_o), .read_o(read_m1_o), .if_instr_o(if_instr), .if_pc_o(if_pc),
		.if_valid_o(if_valid)
	);

	decode_stage decode_i (
		.clk(clk), .reset_n(reset_n), .if_instr_i(if_instr), .if_pc_i(if_pc),
		.if_valid_i(if_valid), .rs_val_i(rs_val), .rt_val_i(rt_val), .rs_addr_o(rs_addr),
		.rt_addr_o(rt_addr), .stall_o(stall), .redirect_o(redirect), .target_o(target),
		.freeze_o(freeze), .squash_o(squash), .ex_o(id_ex.drv)
	);

	register_file register_file_i (
		.clk(clk), .reset_n(reset_n), .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
		.wr_en_i(wb_reg_write), .wr_addr_i(wb_dest), .wr_data_i(wb_data),
		.rs_val_o(rs_val), .rt_val_o(rt_val)
	);

	execute_stage execute_i (
		.clk(clk), .reset_n(reset_n), .wb_reg_write_i(wb_reg_write), .wb_dest_i(wb_dest),
		.wb_data_i(wb_data), .ex_i(id_ex.rcv), .mem_o(ex_mem.drv)
	);

	mem_wb_stage mem_wb_i (
		.clk(clk), .reset_n(reset_n), .data2_i(data2_i), .mem_i(ex_mem.rcv),
		.address2_o(address2_o), .data2_o(data2_o), .read_m2_o(read_m2_o),
		.write_m2_o(write_m2_o), .wb_reg_write_o(wb_reg_write), .wb_dest_o(wb_dest),
		.wb_data_o(wb_data), .num_inst_o(num_inst_o), .output_port_o(output_port_o),
		.is_halted_o(is_halted_o)
	);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage (
	input  logic                clk,
	input  logic                reset_n,
	input  cpu_pkg::word_t      if_instr_i,
	input  cpu_pkg::word_t      if_pc_i,
	input  logic                if_valid_i,
	input  cpu_pkg::word_t      rs_val_i,
	input  cpu_pkg::word_t      rt_val_i,
	output cpu_pkg::reg_addr_t  rs_addr_o,
	output cpu_pkg::reg_addr_t  rt_addr_o,
	output logic                stall_o,
	output logic                redirect_o,
	output cpu_pkg::word_t      target_o,
	output logic                freeze_o,
	output logic                squash_o,
	id_ex_if.drv                ex_o
);
	import cpu_pkg::*;

	opcode_t opcode;
	func_t func;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic [`IMM_HI-`IMM_LO:0] imm8;

	alu_sel_t alu_sel;
	word_t imm;
	reg_addr_t dest;
	logic use_imm;
	logic reg_wr;
	logic mem_rd;
	logic mem_wr;
	logic wwd;
	logic halt;
	logic jump;
	logic uses_rs;
	logic uses_rt;
	logic load_hit;
	logic issue;

	assign opcode = if_instr_i[`OP_HI:`OP_LO];
	assign func = if_instr_i[`FN_HI:`FN_LO];
	assign rs = if_instr_i[`RS_HI:`RS_LO];
	assign rt = if_instr_i[`RT_HI:`RT_LO];
	assign rd = if_instr_i[`RD_HI:`RD_LO];
	assign imm8 = if_instr_i[`IMM_HI:`IMM_LO];

	assign rs_addr_o = rs;
	assign rt_addr_o = rt;

	always_comb begin
		alu_sel = `ALU_ADD;
		imm = '0;
		dest = rt;
		use_imm = 1'b0;
		reg_wr = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		wwd = 1'b0;
		halt = 1'b0;
		jump = 1'b0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			`OP_ADI: begin
				imm = {{8{imm8[7]}}, imm8};
				{use_imm, reg_wr, uses_rs} = 3'b111;
			end
			`OP_ORI: begin
				alu_sel = `ALU_ORR;
				imm = {8'h00, imm8};
				{use_imm, reg_wr, uses_rs} = 3'b111;
			end
			`OP_LHI: begin
				alu_sel = `ALU_PASS_B;
				imm = {imm8, 8'h00};
				{use_imm, reg_wr} = 2'b11;
			end
			`OP_LWD: begin
				imm = {{8{imm8[7]}}, imm8};
				{use_imm, reg_wr, mem_rd, uses_rs} = 4'b1111;
			end
			`OP_SWD: begin
				imm = {{8{imm8[7]}}, imm8};
				{use_imm, mem_wr, uses_rs, uses_rt} = 4'b1111;
			end
			`OP_JMP: jump = 1'b1;
			`OP_RTYPE: begin
				dest = rd;
				if (func == `FN_WWD) begin
					alu_sel = `ALU_PASS_A;
					{wwd, uses_rs} = 2'b11;
				end else if (func == `FN_HLT) begin
					halt = 1'b1;
				end else if (func <= `FN_SHR) begin
					alu_sel = alu_sel_t'(func[3:0]);
					{reg_wr, uses_rs} = 2'b11;
					// NOT, TCP and the shifts take rs only
					uses_rt = (func <= `FN_ORR);
				end
			end
			default: ;
		endcase
	end

	// load in ID/EX feeding this instruction
	assign load_hit = ex_o.valid && ex_o.mem_read &&
		((uses_rs && ex_o.dest == rs) || (uses_rt && ex_o.dest == rt));
	assign stall_o = if_valid_i && load_hit;
	assign redirect_o = if_valid_i && jump;
	assign target_o = {if_pc_i[`WORD_SIZE-1:`TGT_HI+1], if_instr_i[`TGT_HI:`TGT_LO]};
	assign freeze_o = if_valid_i && halt;
	assign squash_o = redirect_o || freeze_o;
	assign issue = if_valid_i && !stall_o;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_o.valid <= 1'b0;
			ex_o.mem_read <= 1'b0;
			ex_o.mem_write <= 1'b0;
			ex_o.reg_write <= 1'b0;
			ex_o.wwd <= 1'b0;
			ex_o.halt <= 1'b0;
		end else begin
			ex_o.valid <= issue;
			ex_o.mem_read <= issue && mem_rd;
			ex_o.mem_write <= issue && mem_wr;
			ex_o.reg_write <= issue && reg_wr;
			ex_o.wwd <= issue && wwd;
			ex_o.halt <= issue && halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_o.rs_val <= rs_val_i;
		ex_o.rt_val <= rt_val_i;
		ex_o.rs <= rs;
		ex_o.rt <= rt;
		ex_o.dest <= dest;
		ex_o.imm <= imm;
		ex_o.alu_sel <= alu_sel;
		ex_o.use_imm <= use_imm;
	end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               wb_reg_write_i,
	input  cpu_pkg::reg_addr_t wb_dest_i,
	input  cpu_pkg::word_t     wb_data_i,
	id_ex_if.rcv               ex_i,
	ex_mem_if.drv              mem_o
);
	import cpu_pkg::*;

	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	word_t rs_fwd;
	word_t rt_fwd;
	word_t op_a;
	word_t op_b;
	word_t alu_result;

	// younger producer in EX/MEM wins over MEM/WB
	always_comb begin
		fwd_a = `FWD_REG;
		if (mem_o.reg_write && mem_o.dest == ex_i.rs)
			fwd_a = `FWD_EXMEM;
		else if (wb_reg_write_i && wb_dest_i == ex_i.rs)
			fwd_a = `FWD_MEMWB;
		fwd_b = `FWD_REG;
		if (mem_o.reg_write && mem_o.dest == ex_i.rt)
			fwd_b = `FWD_EXMEM;
		else if (wb_reg_write_i && wb_dest_i == ex_i.rt)
			fwd_b = `FWD_MEMWB;
	end

	always_comb begin
		case (fwd_a)
			`FWD_EXMEM: rs_fwd = mem_o.alu_result;
			`FWD_MEMWB: rs_fwd = wb_data_i;
			default:    rs_fwd = ex_i.rs_val;
		endcase
		case (fwd_b)
			`FWD_EXMEM: rt_fwd = mem_o.alu_result;
			`FWD_MEMWB: rt_fwd = wb_data_i;
			default:    rt_fwd = ex_i.rt_val;
		endcase
	end

	assign op_a = rs_fwd;
	assign op_b = ex_i.use_imm ? ex_i.imm : rt_fwd;

	always_comb begin
		case (ex_i.alu_sel)
			`ALU_ADD:    alu_result = op_a + op_b;
			`ALU_SUB:    alu_result = op_a - op_b;
			`ALU_AND:    alu_result = op_a & op_b;
			`ALU_ORR:    alu_result = op_a | op_b;
			`ALU_NOT:    alu_result = ~op_a;
			`ALU_TCP:    alu_result = ~op_a + word_t'(1);
			`ALU_SHL:    alu_result = op_a << 1;
			// arithmetic, sign bit kept
			`ALU_SHR:    alu_result = word_t'($signed(op_a) >>> 1);
			`ALU_PASS_B: alu_result = op_b;
			default:     alu_result = op_a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			mem_o.valid <= 1'b0;
			mem_o.mem_read <= 1'b0;
			mem_o.mem_write <= 1'b0;
			mem_o.reg_write <= 1'b0;
			mem_o.wwd <= 1'b0;
			mem_o.halt <= 1'b0;
		end else begin
			mem_o.valid <= ex_i.valid;
			mem_o.mem_read <= ex_i.mem_read;
			mem_o.mem_write <= ex_i.mem_write;
			mem_o.reg_write <= ex_i.reg_write;
			mem_o.wwd <= ex_i.wwd;
			mem_o.halt <= ex_i.halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_o.alu_result <= alu_result;
		mem_o.store_data <= rt_fwd;
		mem_o.dest <= ex_i.dest;
	end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           stall_i,
	input  logic           redirect_i,
	input  cpu_pkg::word_t target_i,
	input  logic           freeze_i,
	input  logic           squash_i,
	input  cpu_pkg::word_t instr_i,
	output cpu_pkg::word_t pc_o,
	output logic           read_o,
	output cpu_pkg::word_t if_instr_o,
	output cpu_pkg::word_t if_pc_o,
	output logic           if_valid_o
);
	import cpu_pkg::*;

	word_t pc;
	logic started;
	logic frozen;
	logic fetching;

	// no fetch in the cycle HLT is decoded, nor ever after
	assign fetching = started && !frozen && !freeze_i;
	assign read_o = fetching;
	assign pc_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			started <= 1'b0;
			frozen <= 1'b0;
			if_valid_o <= 1'b0;
		end else begin
			started <= 1'b1;
			if (freeze_i)
				frozen <= 1'b1;
			if (redirect_i)
				pc <= target_i;
			else if (fetching && !stall_i)
				pc <= pc + 1'b1;
			// squashed slot becomes a bubble in IF/ID
			if (squash_i)
				if_valid_o <= 1'b0;
			else if (!stall_i)
				if_valid_o <= fetching;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if_instr_o <= instr_i;
			if_pc_o <= pc;
		end
	end

	// a jump never sits behind a load-use hazard
	a_no_redirect_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
		!(redirect_i && stall_i));

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic               clk,
	input  logic               reset_n,
	input  cpu_pkg::word_t     data2_i,
	ex_mem_if.rcv              mem_i,
	output cpu_pkg::word_t     address2_o,
	output cpu_pkg::word_t     data2_o,
	output logic               read_m2_o,
	output logic               write_m2_o,
	output logic               wb_reg_write_o,
	output cpu_pkg::reg_addr_t wb_dest_o,
	output cpu_pkg::word_t     wb_data_o,
	output cpu_pkg::word_t     num_inst_o,
	output cpu_pkg::word_t     output_port_o,
	output logic               is_halted_o
);
	logic wb_valid;
	logic wb_wwd;
	logic wb_halt;

	// zero-wait data memory driven straight from EX/MEM
	assign address2_o = mem_i.alu_result;
	assign data2_o = mem_i.store_data;
	assign read_m2_o = mem_i.mem_read;
	assign write_m2_o = mem_i.mem_write;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_valid <= 1'b0;
			wb_reg_write_o <= 1'b0;
			wb_wwd <= 1'b0;
			wb_halt <= 1'b0;
		end else begin
			wb_valid <= mem_i.valid;
			wb_reg_write_o <= mem_i.reg_write;
			wb_wwd <= mem_i.wwd;
			wb_halt <= mem_i.halt;
		end
	end

	always_ff @(posedge clk) begin
		wb_dest_o <= mem_i.dest;
		wb_data_o <= mem_i.mem_read ? data2_i : mem_i.alu_result;
	end

	// retirement
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst_o <= '0;
			output_port_o <= '0;
			is_halted_o <= 1'b0;
		end else begin
			if (wb_valid)
				num_inst_o <= num_inst_o + 1'b1;
			if (wb_wwd)
				output_port_o <= wb_data_o;
			if (wb_halt)
				is_halted_o <= 1'b1;
		end
	end

	// everything behind HLT was squashed upstream
	a_no_retire_after_halt: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_o |-> !wb_valid);

endmodule

// File: design/pipe_if.sv
`timescale 1ns/1ps

// ID/EX pipeline register contents
interface id_ex_if;
	import cpu_pkg::*;

	logic valid;
	word_t rs_val;
	word_t rt_val;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t dest;
	// already extended or shifted
	word_t imm;
	alu_sel_t alu_sel;
	logic use_imm;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic wwd;
	logic halt;

	modport drv (output valid, rs_val, rt_val, rs, rt, dest, imm, alu_sel, use_imm,
		mem_read, mem_write, reg_write, wwd, halt);
	modport rcv (input valid, rs_val, rt_val, rs, rt, dest, imm, alu_sel, use_imm,
		mem_read, mem_write, reg_write, wwd, halt);
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if;
	import cpu_pkg::*;

	logic valid;
	word_t alu_result;
	word_t store_data;
	reg_addr_t dest;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic wwd;
	logic halt;

	modport drv (output valid, alu_result, store_data, dest, mem_read, mem_write,
		reg_write, wwd, halt);
	modport rcv (input valid, alu_result, store_data, dest, mem_read, mem_write,
		reg_write, wwd, halt);
endinterface

// File: design/register_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
	input  logic               clk,
	input  logic               reset_n,
	input  cpu_pkg::reg_addr_t rs_addr_i,
	input  cpu_pkg::reg_addr_t rt_addr_i,
	input  logic               wr_en_i,
	input  cpu_pkg::reg_addr_t wr_addr_i,
	input  cpu_pkg::word_t     wr_data_i,
	output cpu_pkg::word_t     rs_val_o,
	output cpu_pkg::word_t     rt_val_o
);
	import cpu_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en_i) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rs_val_o = (wr_en_i && wr_addr_i == rs_addr_i) ? wr_data_i : regs[rs_addr_i];
	assign rt_val_o = (wr_en_i && wr_addr_i == rt_addr_i) ? wr_data_i : regs[rt_addr_i];

endmodule

// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// word and register file geometry
`define WORD_SIZE   16
`define NUM_REGS    4
`define REG_ADDR_W  2

// opcodes
`define OP_ADI      4'd4
`define OP_ORI      4'd5
`define OP_LHI      4'd6
`define OP_LWD      4'd7
`define OP_SWD      4'd8
`define OP_JMP      4'd9
`define OP_RTYPE    4'd15

// function codes of the R-type group
`define FN_ADD      6'd0
`define FN_SUB      6'd1
`define FN_AND      6'd2
`define FN_ORR      6'd3
`define FN_NOT      6'd4
`define FN_TCP      6'd5
`define FN_SHL      6'd6
`define FN_SHR      6'd7
`define FN_WWD      6'd28
`define FN_HLT      6'd29

// instruction fields
`define OP_HI       15
`define OP_LO       12
`define RS_HI       11
`define RS_LO       10
`define RT_HI       9
`define RT_LO       8
`define RD_HI       7
`define RD_LO       6
`define FN_HI       5
`define FN_LO       0
`define IMM_HI      7
`define IMM_LO      0
`define TGT_HI      11
`define TGT_LO      0

// ALU operations, 0..7 line up with the R-type function codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_ORR     4'd3
`define ALU_NOT     4'd4
`define ALU_TCP     4'd5
`define ALU_SHL     4'd6
`define ALU_SHR     4'd7
`define ALU_PASS_A  4'd8
`define ALU_PASS_B  4'd9

// operand forwarding sources
`define FWD_REG     2'd0
`define FWD_EXMEM   2'd1
`define FWD_MEMWB   2'd2

`endif
